/* rtl/mem_pkg.sv */
package mem_pkg;

    // burst memory moves four 64-bit beats per line
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_W         = BEAT_W * BEATS_PER_LINE;

    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [LINE_W-1:0] line_t;

endpackage : mem_pkg

/* rtl/fetch_pkg.sv */
package fetch_pkg;

    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;

    // one queue slot pairing pc and instruction
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_entry_t;

endpackage : fetch_pkg

/* rtl/line_adapter.sv */
`timescale 1ns/1ps

module line_adapter
import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  beat_t rdata_i,
    input  logic  rvalid_i,

    output line_t line_o,
    output logic  line_valid_o
);

    localparam int CNT_W = $clog2(BEATS_PER_LINE);

    logic [CNT_W-1:0] beat_cnt;
    line_t            line_q;

    // beat slot register
    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            line_q[beat_cnt*BEAT_W +: BEAT_W] <= rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= 1'b0;
            if (rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1; // wraps after the last beat
                if (beat_cnt == CNT_W'(BEATS_PER_LINE - 1)) begin
                    line_valid_o <= 1'b1;
                end
            end
        end
    end

    assign line_o = line_q;

endmodule : line_adapter

/* rtl/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl
import mem_pkg::*;
import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h0000_0000
)
(
    input  logic         clk,
    input  logic         rst,

    // burst memory request side
    input  logic         bmem_ready_i,
    output addr_t        bmem_addr_o,
    output logic         bmem_read_o,

    // assembled line from the adapter
    input  line_t        line_i,
    input  logic         line_valid_i,

    // instruction queue
    input  logic         full_i,
    output logic         enq_o,
    output fetch_entry_t enq_entry_o
);

    localparam int WORDS_PER_LINE = LINE_W / INST_W;
    localparam int SEL_W          = $clog2(WORDS_PER_LINE);
    localparam int OFFSET_W       = $clog2(LINE_W / 8);

    typedef enum logic [1:0] {
        REQ,
        WAIT,
        DRAIN
    } fetch_state_t;

    fetch_state_t           state, state_next;
    addr_t                  pc;
    line_t                  line_q;
    logic [SEL_W-1:0]       word_sel;
    logic                   last_word;

    assign word_sel  = pc[OFFSET_W-1:2];
    assign last_word = (word_sel == SEL_W'(WORDS_PER_LINE - 1));

    assign bmem_addr_o = {pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign bmem_read_o = (state == REQ) && bmem_ready_i;

    assign enq_o             = (state == DRAIN) && !full_i;
    assign enq_entry_o.pc    = pc;
    assign enq_entry_o.inst  = line_q[word_sel*INST_W +: INST_W];

    always_comb begin
        state_next = state;
        unique case (state)
            REQ: begin
                if (bmem_ready_i) begin
                    state_next = WAIT;
                end
            end
            WAIT: begin
                if (line_valid_i) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: begin
                // stall in place while the queue is full
                if (enq_o && last_word) begin
                    state_next = REQ;
                end
            end
            default: state_next = REQ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= REQ;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (enq_o) begin
                pc <= pc + addr_t'(4); // crosses into next line after word 7
            end
        end
    end

    // line held for the whole drain
    always_ff @(posedge clk) begin
        if ((state == WAIT) && line_valid_i) begin
            line_q <= line_i;
        end
    end

endmodule : fetch_ctrl

/* rtl/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue
import fetch_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 8
)
(
    input  logic         clk,
    input  logic         rst,

    input  logic         enq_i,
    input  fetch_entry_t enq_entry_i,

    input  logic         dequeue_i,
    output fetch_entry_t head_o,
    output logic         full_o,
    output logic         empty_o
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    fetch_entry_t     mem [QUEUE_DEPTH];
    logic [IDX_W:0]   head_ptr, tail_ptr; // extra bit tells full from empty
    logic             do_enq, do_deq;

    assign empty_o = (head_ptr == tail_ptr);
    assign full_o  = (head_ptr[IDX_W] != tail_ptr[IDX_W]) &&
                     (head_ptr[IDX_W-1:0] == tail_ptr[IDX_W-1:0]);

    assign do_deq = dequeue_i && !empty_o;         // dequeue on empty is dropped
    assign do_enq = enq_i && (!full_o || do_deq);

    assign head_o = mem[head_ptr[IDX_W-1:0]];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[tail_ptr[IDX_W-1:0]] <= enq_entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (do_enq) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_deq) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

endmodule : inst_queue

/* rtl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
import mem_pkg::*;
import fetch_pkg::*;
#(
    parameter addr_t       RESET_PC    = 32'h1eceb008,
    parameter int unsigned QUEUE_DEPTH = 8
)
(
    input  logic         clk,
    input  logic         rst,

    output addr_t        bmem_addr_o,
    output logic         bmem_read_o,
    input  logic         bmem_ready_i,

    input  addr_t        bmem_raddr_i, // unused since beats come back in order
    input  beat_t        bmem_rdata_i,
    input  logic         bmem_rvalid_i,

    input  logic         dequeue_i,
    output fetch_entry_t head_o,
    output logic         empty_o,
    output logic         full_o
);

    line_t        line;
    logic         line_valid;
    logic         enq;
    fetch_entry_t enq_entry;

    line_adapter line_adapter_i (
        .clk          (clk),
        .rst          (rst),
        .rdata_i      (bmem_rdata_i),
        .rvalid_i     (bmem_rvalid_i),
        .line_o       (line),
        .line_valid_o (line_valid)
    );

    fetch_ctrl #(.RESET_PC(RESET_PC)) fetch_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .bmem_ready_i (bmem_ready_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .line_i       (line),
        .line_valid_i (line_valid),
        .full_i       (full_o),
        .enq_o        (enq),
        .enq_entry_o  (enq_entry)
    );

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_i (
        .clk          (clk),
        .rst          (rst),
        .enq_i        (enq),
        .enq_entry_i  (enq_entry),
        .dequeue_i    (dequeue_i),
        .head_o       (head_o),
        .full_o       (full_o),
        .empty_o      (empty_o)
    );

endmodule : fetch_top

/* test/fetch_asserts.sv */
`timescale 1ns/1ps

module fetch_asserts
import fetch_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  bmem_read_o,
    input logic  bmem_ready_i,
    input addr_t bmem_addr_o,
    input logic  full_o,
    input logic  empty_o
);

    read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> !bmem_read_o)
        else $error("bmem_read_o held longer than one cycle");

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> bmem_ready_i)
        else $error("bmem_read_o raised while bmem_ready_i is low");

    read_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (bmem_addr_o[4:0] == 5'd0))
        else $error("bmem_addr_o not line aligned on a read");

    // queue levels are exclusive
    full_not_empty: assert property (@(posedge clk) disable iff (rst)
        !(full_o && empty_o))
        else $error("full_o and empty_o high together");

endmodule : fetch_asserts

bind fetch_top fetch_asserts fetch_asserts_i (
    .clk          (clk),
    .rst          (rst),
    .bmem_read_o  (bmem_read_o),
    .bmem_ready_i (bmem_ready_i),
    .bmem_addr_o  (bmem_addr_o),
    .full_o       (full_o),
    .empty_o      (empty_o)
);

/* test/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top
import mem_pkg::*;
import fetch_pkg::*;
();

    localparam addr_t       RESET_PC    = 32'h1eceb008;
    localparam int unsigned QUEUE_DEPTH = 8;
    localparam int          NUM_ROWS    = 5;

    typedef enum logic [1:0] {
        DEQ_EVERY,
        DEQ_THIRD,
        DEQ_HOLD
    } deq_mode_t;

    typedef struct packed {
        int        ready_delay;
        int        latency;
        logic      random_gaps;
        int        gap;
        deq_mode_t deq_mode;
        int        entries;
    } row_t;

    logic         clk = 1'b0;
    logic         rst;
    addr_t        bmem_addr_o;
    logic         bmem_read_o;
    logic         bmem_ready_i;
    addr_t        bmem_raddr_i;
    beat_t        bmem_rdata_i;
    logic         bmem_rvalid_i;
    logic         dequeue_i;
    fetch_entry_t head_o;
    logic         empty_o;
    logic         full_o;

    row_t   rows [NUM_ROWS];
    row_t   cur_row;
    logic   table_ready = 1'b0;
    integer seed = 32'ha16fe475;
    addr_t  exp_pc = RESET_PC;
    int     checks = 0;
    int     errors = 0;

    fetch_top #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(QUEUE_DEPTH)) uut (.*);

    always #5 clk = ~clk;

    // instruction word at byte address a
    function automatic inst_t mem_word(input addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    task automatic load_table();
        rows[0] = '{ready_delay: 8, latency: 2, random_gaps: 1'b0, gap: 0,
                    deq_mode: DEQ_EVERY, entries: 20};
        rows[1] = '{ready_delay: 0, latency: 5, random_gaps: 1'b1, gap: 0,
                    deq_mode: DEQ_EVERY, entries: 24};
        rows[2] = '{ready_delay: 3, latency: 1, random_gaps: 1'b0, gap: 2,
                    deq_mode: DEQ_HOLD, entries: 20};
        rows[3] = '{ready_delay: 2, latency: 3, random_gaps: 1'b1, gap: 0,
                    deq_mode: DEQ_THIRD, entries: 20};
        rows[4] = '{ready_delay: 0, latency: 0, random_gaps: 1'b0, gap: 1,
                    deq_mode: DEQ_HOLD, entries: 16};
    endtask

    task automatic check_head(inout int row_err);
        checks++;
        assert (head_o.pc == exp_pc) else begin
            $display("FAILED head_o.pc: got %h, expected %h", head_o.pc, exp_pc);
            errors++;
            row_err++;
        end
        assert (head_o.inst == mem_word(exp_pc)) else begin
            $display("FAILED head_o.inst: got %h, expected %h", head_o.inst, mem_word(exp_pc));
            errors++;
            row_err++;
        end
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic apply_row(input int r);
        row_t row;
        int   cyc;
        int   checked;
        int   row_err;
        int   hold_cyc;
        logic saw_full;
        row      = rows[r];
        cyc      = 0;
        checked  = 0;
        row_err  = 0;
        hold_cyc = 0;
        saw_full = 1'b0;
        @(negedge clk);
        cur_row      = row;
        dequeue_i    = 1'b0;
        bmem_ready_i = 1'b0;
        for (int i = 0; i < row.ready_delay; i++) begin
            @(posedge clk);
            checks++;
            assert (bmem_read_o !== 1'b1) else begin
                $display("FAILED bmem_read_o: got %h, expected 0", bmem_read_o);
                errors++;
                row_err++;
            end
            @(negedge clk);
        end
        bmem_ready_i = 1'b1;
        while (checked < row.entries) begin
            @(negedge clk);
            case (row.deq_mode)
                DEQ_EVERY: dequeue_i = 1'b1;
                DEQ_THIRD: dequeue_i = (cyc % 3 == 0);
                default: begin
                    saw_full = saw_full | full_o; // hold off until the queue fills
                    if (!saw_full) begin
                        hold_cyc++;
                        assert (hold_cyc <= QUEUE_DEPTH * 40) else begin
                            $display("FAILED full_o: got %h, expected 1 after %0d held cycles",
                                     full_o, hold_cyc);
                            errors++;
                            row_err++;
                            saw_full = 1'b1;
                        end
                    end
                    dequeue_i = saw_full;
                end
            endcase
            @(posedge clk);
            cyc++;
            if (dequeue_i && !empty_o) begin
                check_head(row_err);
                checked++;
            end
        end
        $display("row %0d: %0d entries checked, %0d mismatches", r, checked, row_err);
    endtask

    // burst memory model serving one line at a time
    initial begin : mem_model
        addr_t exp_line;
        addr_t base;
        int    gap;
        bmem_rdata_i  = '0;
        bmem_raddr_i  = '0;
        bmem_rvalid_i = 1'b0;
        exp_line      = RESET_PC & ~32'h1f;
        forever begin
            @(posedge clk);
            if (!rst && bmem_read_o === 1'b1) begin
                checks++;
                assert (bmem_addr_o == exp_line) else begin
                    $display("FAILED bmem_addr_o: got %h, expected %h", bmem_addr_o, exp_line);
                    errors++;
                end
                base     = bmem_addr_o;
                exp_line = exp_line + 32'd32;
                @(negedge clk);
                repeat (cur_row.latency) @(negedge clk);
                for (int k = 0; k < BEATS_PER_LINE; k++) begin
                    bmem_raddr_i  = base + addr_t'(8 * k);
                    bmem_rdata_i  = {mem_word(bmem_raddr_i + 32'd4), mem_word(bmem_raddr_i)};
                    bmem_rvalid_i = 1'b1;
                    @(negedge clk);
                    bmem_rvalid_i = 1'b0;
                    if (k < BEATS_PER_LINE - 1) begin
                        gap = cur_row.random_gaps ? ($unsigned($random(seed)) % 4) : cur_row.gap;
                        repeat (gap) @(negedge clk);
                    end
                end
            end
        end
    end

    initial begin : run_rows
        rst          = 1'b1;
        bmem_ready_i = 1'b0;
        dequeue_i    = 1'b0;
        load_table();
        cur_row     = rows[0];
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        checks++;
        assert (empty_o === 1'b1) else begin
            $display("FAILED empty_o: got %h, expected 1", empty_o);
            errors++;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 0;
        foreach (rows[i]) begin
            limit += rows[i].entries * 40 + 200;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the rows did not finish within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule : tb_fetch_top

/* flist.f */
rtl/mem_pkg.sv
rtl/fetch_pkg.sv
rtl/line_adapter.sv
rtl/fetch_ctrl.sv
rtl/inst_queue.sv
rtl/fetch_top.sv
test/fetch_asserts.sv
test/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - files:
      - rtl/mem_pkg.sv
      - rtl/fetch_pkg.sv
      - rtl/line_adapter.sv
      - rtl/fetch_ctrl.sv
      - rtl/inst_queue.sv
      - rtl/fetch_top.sv
  - target: test
    files:
      - test/fetch_asserts.sv
      - test/tb_fetch_top.sv
